/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // word and line geometry
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 16;
    localparam int SET_COUNT  = 64;

    // address field widths
    localparam int BYTE_W   = 2;
    localparam int OFFSET_W = $clog2(LINE_WORDS);
    localparam int INDEX_W  = $clog2(SET_COUNT);
    localparam int TAG_W    = WORD_W - INDEX_W - OFFSET_W - BYTE_W;

    // one burst covers one full line
    localparam logic [7:0] AXI_LEN        = 8'(LINE_WORDS - 1);
    // four bytes per beat
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    typedef logic [WORD_W-1:0] word_t;

    // word slot inside a line, also the beat number
    typedef logic [OFFSET_W-1:0] beat_idx_t;

    // fetch address
    // flat byte view for the bus, field view for lookup and fill
    typedef union packed {
        word_t flat;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
            logic [BYTE_W-1:0]   byte_off;
        } f;
    } fetch_addr_u;

endpackage

`default_nettype wire

/* beat_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module beat_counter (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  clear,
    input  wire logic                  beat,
    output icache_pkg::beat_idx_t      idx,
    output logic                       last
);

    // index of the final beat in a line
    localparam icache_pkg::beat_idx_t LAST_IDX =
        icache_pkg::beat_idx_t'(icache_pkg::LINE_WORDS - 1);

    // count of accepted beats
    // stops at the final beat instead of wrapping
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (clear) begin
            // restart for the next burst
            idx <= '0;
        end else if (beat && !last) begin
            idx <= idx + 1'b1;
        end
    end

    // final beat of the line
    assign last = (idx == LAST_IDX);

endmodule

`default_nettype wire

/* line_store.sv */
`timescale 1ns/10ps
`default_nettype none

module line_store (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     lookup_en,
    input  wire icache_pkg::fetch_addr_u  addr,
    input  wire logic                     fill_en,
    input  wire icache_pkg::beat_idx_t    fill_idx,
    input  wire icache_pkg::word_t        fill_data,
    input  wire logic                     inval_all,
    output logic                          hit,
    output icache_pkg::word_t             rd_data
);

    localparam int DEPTH  = icache_pkg::SET_COUNT * icache_pkg::LINE_WORDS;
    localparam int SLOT_W = icache_pkg::INDEX_W + icache_pkg::OFFSET_W;

    // flat word array, set index above word offset
    icache_pkg::word_t              data_mem [DEPTH];
    logic [icache_pkg::TAG_W-1:0]   tag_mem  [icache_pkg::SET_COUNT];
    logic [icache_pkg::SET_COUNT-1:0] valid;

    logic [SLOT_W-1:0] rd_slot;
    logic [SLOT_W-1:0] wr_slot;
    logic              tag_match;
    logic              fwd;

    // read slot from the full address
    assign rd_slot = {addr.f.index, addr.f.offset};
    // fill slot from the set and the beat number
    assign wr_slot = {addr.f.index, fill_idx};

    assign tag_match = valid[addr.f.index] && (tag_mem[addr.f.index] == addr.f.tag);

    // last beat may land on the word being read at the same edge
    assign fwd = fill_en && (fill_idx == addr.f.offset);

    // one word per beat
    // tag rewritten with each beat of the line
    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[wr_slot]     <= fill_data;
            tag_mem[addr.f.index] <= addr.f.tag;
        end
    end

    // valid bits
    // flush clears every set at once
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (inval_all) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[addr.f.index] <= 1'b1;
        end
    end

    // registered hit flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit <= 1'b0;
        end else if (lookup_en) begin
            hit <= tag_match;
        end
    end

    // registered read word
    // held between strobes so the response stays put under back-pressure
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rd_data <= fwd ? fill_data : data_mem[rd_slot];
        end
    end

endmodule

`default_nettype wire

/* refill_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module refill_fsm #(
    parameter logic [3:0] AXI_ID = 4'd0
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // fetch request and response
    input  wire logic                     req_valid,
    input  wire icache_pkg::fetch_addr_u  req_addr,
    output logic                          req_ready,
    input  wire logic                     flush,
    output logic                          resp_valid,
    input  wire logic                     resp_ready,
    // AXI read address
    output logic                          arvalid,
    input  wire logic                     arready,
    output icache_pkg::word_t             araddr,
    // AXI read data
    input  wire logic                     rvalid,
    input  wire logic [3:0]               rid,
    output logic                          rready,
    // line store control
    output logic                          lookup_en,
    output icache_pkg::fetch_addr_u       lookup_addr,
    input  wire logic                     hit,
    output logic                          fill_en,
    // beat counter control
    output logic                          cnt_clear,
    input  wire logic                     cnt_last,
    output logic                          inval_all
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_LOOKUP  = 3'd1;
    localparam logic [2:0] ST_REQUEST = 3'd2;
    localparam logic [2:0] ST_RECEIVE = 3'd3;
    localparam logic [2:0] ST_RESPOND = 3'd4;

    logic [2:0]              state;
    icache_pkg::fetch_addr_u addr_q;
    icache_pkg::fetch_addr_u line_base;
    logic                    accept;
    logic                    beat_ok;
    logic                    fill_done;

    // request taken only in idle
    assign accept = (state == ST_IDLE) && req_valid;

    // beat of our own burst
    // other ids pass by untouched
    assign beat_ok   = (state == ST_RECEIVE) && rvalid && (rid == AXI_ID);
    assign fill_done = beat_ok && cnt_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    // hit flag registered at the accept edge
                    state <= hit ? ST_RESPOND : ST_REQUEST;
                end
                ST_REQUEST: begin
                    if (arready) begin
                        state <= ST_RECEIVE;
                    end
                end
                ST_RECEIVE: begin
                    if (fill_done) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (resp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request address, held for the whole miss
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_addr;
        end
    end

    // line base for the burst
    always_comb begin
        line_base            = addr_q;
        line_base.f.offset   = '0;
        line_base.f.byte_off = '0;
    end

    assign araddr = line_base.flat;

    // handshake outputs straight from the state
    assign req_ready  = (state == ST_IDLE);
    assign resp_valid = (state == ST_RESPOND);
    assign arvalid    = (state == ST_REQUEST);
    assign rready     = (state == ST_RECEIVE);

    // first read on accept
    // second read on the last beat picks the word from the new line
    assign lookup_en   = accept || fill_done;
    assign lookup_addr = (state == ST_IDLE) ? req_addr : addr_q;

    assign fill_en   = beat_ok;
    // counter held at zero until the burst starts
    assign cnt_clear = (state == ST_REQUEST);
    // flush only between requests
    assign inval_all = flush && (state == ST_IDLE);

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
    parameter logic [3:0] AXI_ID = 4'd0
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // fetch port
    input  wire logic                     req_valid,
    output logic                          req_ready,
    input  wire icache_pkg::fetch_addr_u  req_addr,
    output logic                          resp_valid,
    input  wire logic                     resp_ready,
    output icache_pkg::word_t             resp_data,
    input  wire logic                     flush,
    // AXI read address channel
    output logic [3:0]                    arid,
    output icache_pkg::word_t             araddr,
    output logic [7:0]                    arlen,
    output logic [2:0]                    arsize,
    output logic [1:0]                    arburst,
    output logic                          arvalid,
    input  wire logic                     arready,
    // AXI read data channel
    input  wire logic [3:0]               rid,
    input  wire icache_pkg::word_t        rdata,
    input  wire logic [1:0]               rresp,
    input  wire logic                     rlast,
    input  wire logic                     rvalid,
    output logic                          rready
);

    logic                    lookup_en;
    icache_pkg::fetch_addr_u lookup_addr;
    logic                    hit;
    logic                    fill_en;
    logic                    cnt_clear;
    logic                    cnt_last;
    logic                    inval_all;
    icache_pkg::beat_idx_t   beat_idx;

    // fixed burst shape, one line per request
    assign arid    = AXI_ID;
    assign arlen   = icache_pkg::AXI_LEN;
    assign arsize  = icache_pkg::AXI_SIZE_WORD;
    assign arburst = icache_pkg::AXI_BURST_INCR;

    // control and bus handshakes
    refill_fsm #(
        .AXI_ID (AXI_ID)
    ) i_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_ready   (req_ready),
        .flush       (flush),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rid         (rid),
        .rready      (rready),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .fill_en     (fill_en),
        .cnt_clear   (cnt_clear),
        .cnt_last    (cnt_last),
        .inval_all   (inval_all)
    );

    // counts only beats that are written into the line
    beat_counter i_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (cnt_clear),
        .beat  (fill_en),
        .idx   (beat_idx),
        .last  (cnt_last)
    );

    // arrays, response word comes from its read register
    line_store i_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .lookup_en (lookup_en),
        .addr      (lookup_addr),
        .fill_en   (fill_en),
        .fill_idx  (beat_idx),
        .fill_data (rdata),
        .inval_all (inval_all),
        .hit       (hit),
        .rd_data   (resp_data)
    );

endmodule

`default_nettype wire

/* icache_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_asserts (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire logic              arvalid,
    input wire logic              arready,
    input wire icache_pkg::word_t araddr,
    input wire logic [3:0]        arid,
    input wire logic              rvalid,
    input wire logic              rready,
    input wire logic [3:0]        rid,
    input wire logic              rlast,
    input wire logic              resp_valid,
    input wire logic              resp_ready
);

    // byte and word offset bits of a line base
    localparam int ALIGN_W = icache_pkg::OFFSET_W + 2;

    logic beat_acc;
    int   beat_cnt;

    // beat of our own burst
    assign beat_acc = rvalid && rready && (rid == arid);

    // beats taken since the last address handshake
    always_ff @(posedge clk) begin
        if (!rst_n || (arvalid && arready)) begin
            beat_cnt <= 0;
        end else if (beat_acc) begin
            beat_cnt <= beat_cnt + 1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    ar_align: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> (araddr[ALIGN_W-1:0] == '0))
        else $error("araddr is not a line base");

    // rlast exactly on the sixteenth beat
    r_last: assert property (@(posedge clk) disable iff (!rst_n)
        beat_acc |-> (rlast == (beat_cnt == icache_pkg::LINE_WORDS - 1)))
        else $error("rlast does not match the final beat of the line");

    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid)
        else $error("resp_valid dropped before resp_ready");

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset low for the first few edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache;

    localparam logic [3:0] TB_ID   = 4'd3;
    localparam int         MAX_OPS = 64;

    logic clk;
    logic rst_n;
    // DUT inputs
    logic                    req_valid  = 1'b0;
    icache_pkg::fetch_addr_u req_addr   = '0;
    logic                    resp_ready = 1'b0;
    logic                    flush      = 1'b0;
    logic                    arready    = 1'b0;
    logic                    rvalid     = 1'b0;
    logic                    rlast      = 1'b0;
    icache_pkg::word_t       rdata      = '0;
    // DUT outputs
    logic                    req_ready;
    logic                    resp_valid;
    icache_pkg::word_t       resp_data;
    logic [3:0]              arid;
    icache_pkg::word_t       araddr;
    logic [7:0]              arlen;
    logic [2:0]              arsize;
    logic [1:0]              arburst;
    logic                    arvalid;
    logic                    rready;
    // memory model state
    logic                    busy    = 1'b0;
    int                      beat_no = 0;
    icache_pkg::word_t       base    = '0;

    int ar_count     = 0;
    int resp_count   = 0;
    int word_errors  = 0;
    int count_errors = 0;
    int flag_errors  = 0;
    int ar_errors    = 0;
    int n_ops        = 0;
    int seed         = 32'h336a;

    // four words per operation
    // op code, byte address, expected word and miss flag
    icache_pkg::word_t golden [4*MAX_OPS];

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) i_clk_gen (.clk(clk), .rst_n(rst_n));

    icache_top #(.AXI_ID(TB_ID)) i_dut (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_data(resp_data),
        .flush(flush),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready),
        .rid(TB_ID), .rdata(rdata), .rresp(2'b00), .rlast(rlast),
        .rvalid(rvalid), .rready(rready)
    );

    bind icache_top icache_asserts i_asserts (
        .clk(clk), .rst_n(rst_n),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid),
        .rvalid(rvalid), .rready(rready), .rid(rid), .rlast(rlast),
        .resp_valid(resp_valid), .resp_ready(resp_ready)
    );

    // read address fields packed as {arid, arlen, arsize, arburst}
    task automatic check_ar_fields(input string name, input logic [16:0] exp,
                                   input logic [16:0] act);
        if (act !== exp) begin
            ar_errors = ar_errors + 1;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // AXI read slave
    // word at byte address a is a ^ 32'h5a5a_a5a5
    always @(posedge clk) begin
        int                nb;
        logic              nbusy;
        icache_pkg::word_t nbase;
        nb    = beat_no;
        nbusy = busy;
        nbase = base;
        if (!rst_n) begin
            busy    <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (rvalid && rready) begin
                nb = nb + 1;
            end
            if (nb == icache_pkg::LINE_WORDS) begin
                nbusy = 1'b0;
            end
            // new burst restarts at the line base
            if (arvalid && arready) begin
                nbusy    = 1'b1;
                nb       = 0;
                nbase    = araddr;
                ar_count <= ar_count + 1;
                // a whole line in one INCR burst of 4-byte beats
                check_ar_fields($sformatf("burst %0d fields", ar_count),
                                {TB_ID, 8'(icache_pkg::LINE_WORDS - 1), 3'b010, 2'b01},
                                {arid, arlen, arsize, arburst});
            end
            busy    <= nbusy;
            beat_no <= nb;
            base    <= nbase;
            arready <= !nbusy && (($random(seed) & 1) != 0);
            // a presented beat stays until taken
            if (!rvalid || rready) begin
                rvalid <= nbusy && (($random(seed) & 3) != 0);
                rdata  <= (nbase + 32'(nb * 4)) ^ 32'h5a5a_a5a5;
                rlast  <= (nb == icache_pkg::LINE_WORDS - 1);
            end
        end
    end

    // response handshakes over the whole run
    always @(posedge clk) begin
        if (rst_n && resp_valid && resp_ready) begin
            resp_count <= resp_count + 1;
        end
    end

    task automatic check_word(input string name, input icache_pkg::word_t exp,
                              input icache_pkg::word_t act);
        if (act !== exp) begin
            word_errors = word_errors + 1;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            count_errors = count_errors + 1;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors = flag_errors + 1;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic run_fetch(input int n, input icache_pkg::word_t addr,
                             input icache_pkg::word_t exp_word, input logic exp_miss);
        int                ar_before;
        logic              done;
        icache_pkg::word_t got;
        ar_before = ar_count;
        done      = 1'b0;
        got       = '0;
        req_valid     <= 1'b1;
        req_addr.flat <= addr;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        req_valid <= 1'b0;
        // random back-pressure on the response
        while (!done) begin
            resp_ready <= (($random(seed) & 3) != 0);
            @(posedge clk);
            // busy from acceptance until the response is taken
            check_flag($sformatf("op %0d req_ready", n), 1'b0, req_ready);
            if (resp_valid && resp_ready) begin
                done = 1'b1;
                got  = resp_data;
            end
        end
        // resp_ready stays high until the next fetch
        // so any extra response adds to the handshake count
        check_word($sformatf("op %0d word", n), exp_word, got);
        check_count($sformatf("op %0d bursts", n), exp_miss ? 1 : 0, ar_count - ar_before);
    endtask

    task automatic apply_flush();
        flush <= 1'b1;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        flush <= 1'b0;
    endtask

    initial begin
        int n_fetch;
        n_fetch = 0;
        $readmemh("icache_golden.txt", golden);
        // op f ends the list
        while (n_ops < MAX_OPS && golden[4*n_ops] != 32'hf) begin
            n_ops = n_ops + 1;
        end
        @(posedge clk);
        while (!rst_n) @(posedge clk);
        for (int i = 0; i < n_ops; i++) begin
            if (golden[4*i] == 32'h1) begin
                apply_flush();
            end else begin
                n_fetch = n_fetch + 1;
                run_fetch(i, golden[4*i+1], golden[4*i+2], golden[4*i+3][0]);
            end
        end
        repeat (2) @(posedge clk);
        check_count("responses", n_fetch, resp_count);
        $display("errors: %0d word, %0d count, %0d flag, %0d burst",
                 word_errors, count_errors, flag_errors, ar_errors);
        if (word_errors + count_errors + flag_errors + ar_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // budget grows with the number of operations
    initial begin
        #1;
        repeat (n_ops * 200) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", n_ops * 200);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* icache_golden.txt */
// op (0 fetch, 1 flush, f end), byte address, expected word, expected miss
// expected word is address ^ 5a5aa5a5
0 00001008 5a5ab5ad 1
0 0000103c 5a5ab599 0
0 00001000 5a5ab5a5 0
0 00003004 5a5a95a1 1
0 00001008 5a5ab5ad 1
0 00002040 5a5a85e5 1
0 0000207c 5a5a85d9 0
1 00000000 00000000 0
0 00002040 5a5a85e5 1
0 00001008 5a5ab5ad 1
0 deadbee0 84f71b45 1
0 deadbefc 84f71b59 0
0 12345678 486ef3dd 1
0 12345640 486ef3e5 0
0 00001010 5a5ab5b5 0
1 00000000 00000000 0
0 12345644 486ef3e1 1
0 0000103c 5a5ab599 1
f 00000000 00000000 0

/* build.f */
icache_pkg.sv
beat_counter.sv
line_store.sv
refill_fsm.sv
icache_top.sv
icache_asserts.sv
tb_clock_gen.sv
tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_icache -f build.f -o tb_icache
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_icache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '>>> PASS' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
